//--- flist.f
rtl/cpuPkg.sv
rtl/pipePkg.sv
rtl/pipeReg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/pipelineCpu.sv
bench/clockGen.sv
bench/tbPipelineCpu.sv

//--- Makefile
TOP = tbPipelineCpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

//--- bench/tbPipelineCpu.sv
module tbPipelineCpu;

	localparam int progLen = 60;
	localparam int loopAddr = progLen - 1;
	localparam int progCount = 3;
	localparam int cycleLimit = progCount * progLen * 3 + 100;

	logic CLK;
	logic porRst;
	logic tbRst;
	logic RST;
	cpuPkg::wordT imemAddr;
	cpuPkg::wordT imemData;
	cpuPkg::wordT dmemAddr;
	cpuPkg::wordT dmemWData;
	logic dmemRead;
	logic dmemWrite;
	cpuPkg::wordT dmemRData;
	logic wbValid;
	cpuPkg::regIdxT wbReg;
	cpuPkg::wordT wbData;

	logic [15:0] imem [0:255];
	logic [15:0] dmem [0:65535];
	logic [15:0] modelMem [0:65535];

	// expected register writes, stores and load addresses, in program order
	logic [2:0] expReg [$];
	logic [15:0] expVal [$];
	logic [15:0] expAddr [$];
	logic [15:0] expData [$];
	logic [15:0] expLoad [$];

	logic running;
	int errors;
	int checks;
	int cycles;
	int loopFetches;
	logic [2:0] nextReg;
	logic [15:0] nextVal;
	logic [15:0] nextAddr;
	logic [15:0] nextData;
	logic [15:0] nextLoad;

	clockGen clocks (.CLK(CLK), .porRst(porRst));

	assign RST = porRst & tbRst;
	assign imemData = imem[imemAddr[7:0]];
	assign dmemRData = dmem[dmemAddr];

	pipelineCpu u_dut (.CLK(CLK), .RST(RST), .imemAddr(imemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemWData(dmemWData), .dmemRead(dmemRead),
		.dmemWrite(dmemWrite), .dmemRData(dmemRData), .wbValid(wbValid), .wbReg(wbReg),
		.wbData(wbData));

	// ------------------------------
	// instruction encoding
	// ------------------------------
	function automatic logic [15:0] encReg(logic [4:0] op, logic [2:0] x, logic [2:0] y,
		logic [2:0] z);
		return {op, x, y, z, 2'b00};
	endfunction

	function automatic logic [15:0] encImm(logic [4:0] op, logic [2:0] x, logic [7:0] imm);
		return {op, x, imm};
	endfunction

	function automatic logic [15:0] encMem(logic [4:0] op, logic [2:0] x, logic [2:0] y,
		logic [4:0] imm);
		return {op, x, y, imm};
	endfunction

	function automatic logic [2:0] randReg();
		return 3'($urandom % 8);
	endfunction

	// same pattern for both copies, mixes every address bit
	task automatic fillMem();
		logic [15:0] a;
		for (int k = 0; k < 65536; k++)
		begin
			a = 16'(k);
			dmem[k] = (a * 16'h9e37) ^ {a[7:0], a[15:8]} ^ 16'ha5c3;
			modelMem[k] = dmem[k];
		end
	endtask

	// forward-only control flow, so every program ends at the self loop
	task automatic buildProgram();
		int i;
		int sel;
		int off;
		int tgt;
		logic [2:0] r;
		for (int k = 0; k < 256; k++)
			imem[k] = 16'h0000;
		i = 0;
		while (i < progLen - 3)
		begin
			sel = int'($urandom % 14);
			r = randReg();
			off = int'($urandom % 4);
			if (off > progLen - 2 - i)
				off = progLen - 2 - i;
			case (sel)
				1, 2, 3, 4, 5:
					imem[i] = encReg(5'(sel), r, randReg(), randReg());
				6, 7:
					imem[i] = encImm(5'(sel), r, 8'($urandom));
				8, 9:
					if (i <= progLen - 5)
					begin
						imem[i] = encImm(cpuPkg::opLi, r, 8'($urandom % 24));
						i++;
						imem[i] = encMem(5'(sel), r, randReg(), 5'($urandom % 8));
					end
				10, 11:
					imem[i] = encImm(5'(sel), r, 8'(off));
				12:
					imem[i] = {cpuPkg::opB, 11'(off)};
				13:
					if (i <= progLen - 5)
					begin
						tgt = i + 2 + off;
						if (tgt > loopAddr)
							tgt = loopAddr;
						imem[i] = encImm(cpuPkg::opLi, r, 8'(tgt));
						i++;
						imem[i] = encImm(cpuPkg::opJr, r, 8'h00);
					end
				default:
					imem[i] = 16'h0000;
			endcase
			i++;
		end
		imem[loopAddr] = {cpuPkg::opB, 11'h7ff};
	endtask

	// ------------------------------
	// ISA model
	// ------------------------------
	task automatic runModel();
		logic [15:0] r [8];
		logic [15:0] pc;
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] addr;
		logic [2:0] x;
		logic [2:0] y;
		logic [2:0] z;
		int steps;
		for (int k = 0; k < 8; k++)
			r[k] = 16'h0000;
		pc = 16'h0000;
		steps = 0;
		while (pc != 16'(loopAddr) && steps < 1000)
		begin
			ins = imem[pc[7:0]];
			x = ins[10:8];
			y = ins[7:5];
			z = ins[4:2];
			a = r[x];
			b = r[y];
			addr = a + {{11{ins[4]}}, ins[4:0]};
			pc = pc + 16'd1;
			case (ins[15:11])
				5'd1:
				begin
					r[z] = a + b;
					expReg.push_back(z);
					expVal.push_back(r[z]);
				end
				5'd2:
				begin
					r[z] = a - b;
					expReg.push_back(z);
					expVal.push_back(r[z]);
				end
				5'd3:
				begin
					r[z] = a & b;
					expReg.push_back(z);
					expVal.push_back(r[z]);
				end
				5'd4:
				begin
					r[z] = a | b;
					expReg.push_back(z);
					expVal.push_back(r[z]);
				end
				5'd5:
				begin
					r[z] = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
					expReg.push_back(z);
					expVal.push_back(r[z]);
				end
				5'd6:
				begin
					r[x] = a + {{8{ins[7]}}, ins[7:0]};
					expReg.push_back(x);
					expVal.push_back(r[x]);
				end
				5'd7:
				begin
					r[x] = {8'h00, ins[7:0]};
					expReg.push_back(x);
					expVal.push_back(r[x]);
				end
				5'd8:
				begin
					r[y] = modelMem[addr];
					expReg.push_back(y);
					expVal.push_back(r[y]);
					expLoad.push_back(addr);
				end
				5'd9:
				begin
					modelMem[addr] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
				end
				5'd10: if (a == 16'h0000) pc = pc + {{8{ins[7]}}, ins[7:0]};
				5'd11: if (a != 16'h0000) pc = pc + {{8{ins[7]}}, ins[7:0]};
				5'd12: pc = pc + {{5{ins[10]}}, ins[10:0]};
				5'd13: pc = a;
				default: ;
			endcase
			steps++;
		end
	endtask

	// ------------------------------
	// response checks
	// ------------------------------
	always @(posedge CLK)
	begin
		if (RST && dmemWrite)
			dmem[dmemAddr] = dmemWData;
	end

	always @(negedge CLK)
	begin
		if (running)
		begin
			if (imemAddr == 16'(loopAddr))
				loopFetches++;
			if (wbValid)
			begin
				checks++;
				if (expReg.size() == 0)
				begin
					$display("Error at %0t: write-back to r%0d that the program never makes",
						$time, wbReg);
					errors++;
				end
				else
				begin
					nextReg = expReg.pop_front();
					nextVal = expVal.pop_front();
					if (wbReg !== nextReg)
					begin
						$display("Error at %0t: wbReg expected %0d got %0d", $time, nextReg, wbReg);
						errors++;
					end
					if (wbData !== nextVal)
					begin
						$display("Error at %0t: wbData expected %h got %h", $time, nextVal, wbData);
						errors++;
					end
				end
			end
			if (dmemWrite)
			begin
				checks++;
				if (expAddr.size() == 0)
				begin
					$display("Error at %0t: store to %h that the program never makes",
						$time, dmemAddr);
					errors++;
				end
				else
				begin
					nextAddr = expAddr.pop_front();
					nextData = expData.pop_front();
					if (dmemAddr !== nextAddr)
					begin
						$display("Error at %0t: dmemAddr expected %h got %h", $time, nextAddr,
							dmemAddr);
						errors++;
					end
					if (dmemWData !== nextData)
					begin
						$display("Error at %0t: dmemWData expected %h got %h", $time, nextData,
							dmemWData);
						errors++;
					end
				end
			end
			if (dmemRead)
			begin
				checks++;
				if (expLoad.size() == 0)
				begin
					$display("Error at %0t: load from %h that the program never makes",
						$time, dmemAddr);
					errors++;
				end
				else
				begin
					nextLoad = expLoad.pop_front();
					if (dmemAddr !== nextLoad)
					begin
						$display("Error at %0t: dmemAddr expected %h got %h", $time, nextLoad,
							dmemAddr);
						errors++;
					end
				end
			end
		end
	end

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			errors++;
			$display("checks %0d, errors %0d", checks, errors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ------------------------------
	// run sequence
	// ------------------------------
	initial
	begin
		void'($urandom(32'hf2eba2bb));
		tbRst = 1'b1;
		running = 1'b0;
		errors = 0;
		checks = 0;
		cycles = 0;
		loopFetches = 0;
		for (int p = 0; p < progCount; p++)
		begin
			if (p > 0)
			begin
				@(posedge CLK);
				#1 tbRst = 1'b0;
			end
			fillMem();
			buildProgram();
			runModel();
			if (p > 0)
			begin
				repeat (8) @(posedge CLK);
				#1 tbRst = 1'b1;
			end
			else
				wait (RST === 1'b1);
			@(negedge CLK);
			checks++;
			if (imemAddr !== 16'h0000)
			begin
				$display("Error at %0t: imemAddr expected 0000 got %h", $time, imemAddr);
				errors++;
			end
			if (wbValid !== 1'b0 || dmemWrite !== 1'b0 || dmemRead !== 1'b0)
			begin
				$display("Error at %0t: memory or write-back port active after reset", $time);
				errors++;
			end
			loopFetches = 0;
			running = 1'b1;
			// three passes of the self loop drain everything older
			while (loopFetches < 3)
				@(negedge CLK);
			running = 1'b0;
			if (expReg.size() != 0 || expAddr.size() != 0 || expLoad.size() != 0)
			begin
				$display("program %0d ended with %0d write-backs, %0d stores, %0d loads missing",
					p, expReg.size(), expAddr.size(), expLoad.size());
				errors++;
			end
			expReg.delete();
			expVal.delete();
			expAddr.delete();
			expData.delete();
			expLoad.delete();
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- bench/clockGen.sv
module clockGen (
	output logic CLK,
	output logic porRst
);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// power-on reset, low for 8 cycles
	initial
	begin
		porRst = 1'b0;
		repeat (8) @(posedge CLK);
		#1 porRst = 1'b1;
	end

endmodule

//--- rtl/pipelineCpu.sv
module pipelineCpu (
	input  logic           CLK,
	input  logic           RST,
	output cpuPkg::wordT   imemAddr,
	input  cpuPkg::wordT   imemData,
	output cpuPkg::wordT   dmemAddr,
	output cpuPkg::wordT   dmemWData,
	output logic           dmemRead,
	output logic           dmemWrite,
	input  cpuPkg::wordT   dmemRData,
	output logic           wbValid,
	output cpuPkg::regIdxT wbReg,
	output cpuPkg::wordT   wbData
);

	cpuPkg::wordT    pc;
	cpuPkg::wordT    nextPc;
	pipePkg::ifIdT   ifIdIn;
	pipePkg::ifIdT   ifIdQ;
	pipePkg::idExT   idExIn;
	pipePkg::idExT   idExQ;
	pipePkg::exMemT  exMemIn;
	pipePkg::exMemT  exMemQ;
	pipePkg::memWbT  memWbIn;
	pipePkg::memWbT  memWbQ;
	cpuPkg::wordT    decInstr;
	pipePkg::ctrlT   decCtrl;
	cpuPkg::regIdxT  decRx;
	cpuPkg::regIdxT  decRy;
	cpuPkg::regIdxT  decDest;
	cpuPkg::wordT    decImm;
	cpuPkg::wordT    valA;
	cpuPkg::wordT    valB;
	logic            stall;
	pipePkg::fwdSelT fwdA;
	pipePkg::fwdSelT fwdB;
	logic            redirect;
	cpuPkg::wordT    redirectPc;

	// ------------------------------
	// fetch
	// ------------------------------
	assign nextPc = redirect ? redirectPc : (stall ? pc : pc + cpuPkg::wordT'(1));

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			pc <= '0;
		else
			pc <= nextPc;
	end

	assign imemAddr = pc;

	always_comb
	begin
		ifIdIn.valid = 1'b1;
		ifIdIn.pc = pc;
		ifIdIn.instr = imemData;
	end

	pipeReg #(.payloadT(pipePkg::ifIdT)) ifIdReg (.CLK(CLK), .RST(RST), .stall(stall),
		.flush(redirect), .d(ifIdIn), .q(ifIdQ));

	// ------------------------------
	// decode
	// ------------------------------
	// a bubble decodes as NOP
	assign decInstr = ifIdQ.valid ? ifIdQ.instr : cpuPkg::nopWord;

	instrDecoder decoder (.instr(decInstr), .ctrl(decCtrl), .rx(decRx), .ry(decRy),
		.dest(decDest), .imm(decImm));

	regFile regs (.CLK(CLK), .RST(RST), .rdA(decRx), .rdB(decRy), .valA(valA), .valB(valB),
		.we(wbValid), .wAddr(wbReg), .wData(wbData));

	hazardUnit hazard (.idCtrl(decCtrl), .idRx(decRx), .idRy(decRy), .exStage(idExQ),
		.memStage(exMemQ), .wbStage(memWbQ), .stall(stall), .fwdA(fwdA), .fwdB(fwdB));

	always_comb
	begin
		idExIn.valid = ifIdQ.valid;
		idExIn.ctrl = decCtrl;
		idExIn.pc = ifIdQ.pc;
		idExIn.rxVal = valA;
		idExIn.ryVal = valB;
		idExIn.imm = decImm;
		idExIn.rx = decRx;
		idExIn.ry = decRy;
		idExIn.dest = decDest;
	end

	// stall inserts the load-use bubble here
	pipeReg #(.payloadT(pipePkg::idExT)) idExReg (.CLK(CLK), .RST(RST), .stall(1'b0),
		.flush(redirect || stall), .d(idExIn), .q(idExQ));

	// ------------------------------
	// execute, memory, write-back
	// ------------------------------
	executeStage execute (.ex(idExQ), .fwdA(fwdA), .fwdB(fwdB),
		.memResult(exMemQ.aluResult), .wbResult(memWbQ.result), .out(exMemIn),
		.redirect(redirect), .redirectPc(redirectPc));

	pipeReg #(.payloadT(pipePkg::exMemT)) exMemReg (.CLK(CLK), .RST(RST), .stall(1'b0),
		.flush(1'b0), .d(exMemIn), .q(exMemQ));

	assign dmemAddr = exMemQ.aluResult;
	assign dmemWData = exMemQ.storeData;
	assign dmemRead = exMemQ.valid && exMemQ.memRead;
	assign dmemWrite = exMemQ.valid && exMemQ.memWrite;

	always_comb
	begin
		memWbIn.valid = exMemQ.valid;
		memWbIn.regWrite = exMemQ.regWrite;
		memWbIn.result = exMemQ.memRead ? dmemRData : exMemQ.aluResult;
		memWbIn.dest = exMemQ.dest;
	end

	pipeReg #(.payloadT(pipePkg::memWbT)) memWbReg (.CLK(CLK), .RST(RST), .stall(1'b0),
		.flush(1'b0), .d(memWbIn), .q(memWbQ));

	assign wbValid = memWbQ.valid && memWbQ.regWrite;
	assign wbReg = memWbQ.dest;
	assign wbData = memWbQ.result;

	dataPortExclusive: assert property (@(posedge CLK) disable iff (!RST)
		!(dmemRead && dmemWrite))
		else $error("dmemRead and dmemWrite high together");

endmodule

//--- rtl/executeStage.sv
module executeStage (
	input  pipePkg::idExT   ex,
	input  pipePkg::fwdSelT fwdA,
	input  pipePkg::fwdSelT fwdB,
	input  cpuPkg::wordT    memResult,
	input  cpuPkg::wordT    wbResult,
	output pipePkg::exMemT  out,
	output logic            redirect,
	output cpuPkg::wordT    redirectPc
);

	cpuPkg::wordT opA;
	cpuPkg::wordT opB;
	cpuPkg::wordT aluB;
	cpuPkg::wordT aluResult;
	logic         taken;

	// ------------------------------
	// forwarding muxes
	// ------------------------------
	always_comb
	begin
		case (fwdA)
			pipePkg::fwdFromMem: opA = memResult;
			pipePkg::fwdFromWb:  opA = wbResult;
			default:             opA = ex.rxVal;
		endcase
		case (fwdB)
			pipePkg::fwdFromMem: opB = memResult;
			pipePkg::fwdFromWb:  opB = wbResult;
			default:             opB = ex.ryVal;
		endcase
	end

	// ------------------------------
	// ALU
	// ------------------------------
	assign aluB = ex.ctrl.srcImm ? ex.imm : opB;

	always_comb
	begin
		case (ex.ctrl.aluOp)
			pipePkg::aluSub:   aluResult = opA - aluB;
			pipePkg::aluAnd:   aluResult = opA & aluB;
			pipePkg::aluOr:    aluResult = opA | aluB;
			pipePkg::aluSlt:   aluResult = ($signed(opA) < $signed(aluB)) ?
				cpuPkg::wordT'(1) : '0;
			pipePkg::aluPassB: aluResult = aluB;
			default:           aluResult = opA + aluB;
		endcase
	end

	// ------------------------------
	// branch and jump resolution
	// ------------------------------
	always_comb
	begin
		taken = 1'b0;
		if (ex.ctrl.branchZero && opA == '0)
			taken = 1'b1;
		if (ex.ctrl.branchNonZero && opA != '0)
			taken = 1'b1;
		if (ex.ctrl.jumpImm || ex.ctrl.jumpReg)
			taken = 1'b1;
	end

	assign redirect = ex.valid && taken;
	// relative targets count from the next instruction
	assign redirectPc = ex.ctrl.jumpReg ? opA : ex.pc + cpuPkg::wordT'(1) + ex.imm;

	always_comb
	begin
		out.valid = ex.valid;
		out.regWrite = ex.ctrl.regWrite;
		out.memRead = ex.ctrl.memRead;
		out.memWrite = ex.ctrl.memWrite;
		out.aluResult = aluResult;
		out.storeData = opB;
		out.dest = ex.dest;
	end

endmodule

//--- rtl/hazardUnit.sv
module hazardUnit (
	input  pipePkg::ctrlT   idCtrl,
	input  cpuPkg::regIdxT  idRx,
	input  cpuPkg::regIdxT  idRy,
	input  pipePkg::idExT   exStage,
	input  pipePkg::exMemT  memStage,
	input  pipePkg::memWbT  wbStage,
	output logic            stall,
	output pipePkg::fwdSelT fwdA,
	output pipePkg::fwdSelT fwdB
);

	logic exIsLoad;
	logic memWrites;
	logic wbWrites;

	// ------------------------------
	// load-use detection
	// ------------------------------
	assign exIsLoad = exStage.valid && exStage.ctrl.memRead;

	assign stall = exIsLoad &&
		((idCtrl.useRx && idRx == exStage.dest) ||
		(idCtrl.useRy && idRy == exStage.dest));

	// ------------------------------
	// operand forwarding
	// ------------------------------
	assign memWrites = memStage.valid && memStage.regWrite;
	assign wbWrites = wbStage.valid && wbStage.regWrite;

	// memory stage holds the younger result
	assign fwdA = (memWrites && memStage.dest == exStage.rx) ? pipePkg::fwdFromMem :
		(wbWrites && wbStage.dest == exStage.rx) ? pipePkg::fwdFromWb :
		pipePkg::fwdNone;

	assign fwdB = (memWrites && memStage.dest == exStage.ry) ? pipePkg::fwdFromMem :
		(wbWrites && wbStage.dest == exStage.ry) ? pipePkg::fwdFromWb :
		pipePkg::fwdNone;

	// load data exists only from write-back on, so its user never sits right behind it
	loadNotFromMem: assert final (!(memWrites && memStage.memRead &&
		((exStage.ctrl.useRx && fwdA == pipePkg::fwdFromMem) ||
		(exStage.ctrl.useRy && fwdB == pipePkg::fwdFromMem))))
		else $error("load address forwarded as data from the memory stage");

endmodule

//--- rtl/regFile.sv
module regFile (
	input  logic           CLK,
	input  logic           RST,
	input  cpuPkg::regIdxT rdA,
	input  cpuPkg::regIdxT rdB,
	output cpuPkg::wordT   valA,
	output cpuPkg::wordT   valB,
	input  logic           we,
	input  cpuPkg::regIdxT wAddr,
	input  cpuPkg::wordT   wData
);

	cpuPkg::wordT regs [cpuPkg::regCount];

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			regs <= '{default: '0};
		else if (we)
			regs[wAddr] <= wData;
	end

	// write-back and decode share a cycle, so the new value bypasses
	always_comb
	begin
		if (we && wAddr == rdA)
			valA = wData;
		else
			valA = regs[rdA];
		if (we && wAddr == rdB)
			valB = wData;
		else
			valB = regs[rdB];
	end

endmodule

//--- rtl/instrDecoder.sv
module instrDecoder (
	input  cpuPkg::wordT   instr,
	output pipePkg::ctrlT  ctrl,
	output cpuPkg::regIdxT rx,
	output cpuPkg::regIdxT ry,
	output cpuPkg::regIdxT dest,
	output cpuPkg::wordT   imm
);

	cpuPkg::opcodeT op;
	cpuPkg::regIdxT rz;
	cpuPkg::wordT   simm8;
	cpuPkg::wordT   zimm8;
	cpuPkg::wordT   simm5;
	cpuPkg::wordT   simm11;

	assign op = cpuPkg::opcodeT'(instr[cpuPkg::opcodeMsb:cpuPkg::opcodeLsb]);
	assign rx = instr[cpuPkg::rxMsb:cpuPkg::rxLsb];
	assign ry = instr[cpuPkg::ryMsb:cpuPkg::ryLsb];
	assign rz = instr[cpuPkg::rzMsb:cpuPkg::rzLsb];

	// ------------------------------
	// immediate extension
	// ------------------------------
	assign simm8 = {{(cpuPkg::dataWidth - cpuPkg::imm8Width){instr[cpuPkg::imm8Width-1]}},
		instr[cpuPkg::imm8Width-1:0]};
	assign zimm8 = {{(cpuPkg::dataWidth - cpuPkg::imm8Width){1'b0}},
		instr[cpuPkg::imm8Width-1:0]};
	assign simm5 = {{(cpuPkg::dataWidth - cpuPkg::imm5Width){instr[cpuPkg::imm5Width-1]}},
		instr[cpuPkg::imm5Width-1:0]};
	assign simm11 = {{(cpuPkg::dataWidth - cpuPkg::imm11Width){instr[cpuPkg::imm11Width-1]}},
		instr[cpuPkg::imm11Width-1:0]};

	always_comb
	begin
		ctrl = '0;
		dest = '0;
		imm = '0;
		case (op)
			cpuPkg::opAddu,
			cpuPkg::opSubu,
			cpuPkg::opAnd,
			cpuPkg::opOr,
			cpuPkg::opSlt:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.useRx = 1'b1;
				ctrl.useRy = 1'b1;
				dest = rz;
				case (op)
					cpuPkg::opSubu: ctrl.aluOp = pipePkg::aluSub;
					cpuPkg::opAnd:  ctrl.aluOp = pipePkg::aluAnd;
					cpuPkg::opOr:   ctrl.aluOp = pipePkg::aluOr;
					cpuPkg::opSlt:  ctrl.aluOp = pipePkg::aluSlt;
					default:        ctrl.aluOp = pipePkg::aluAdd;
				endcase
			end
			cpuPkg::opAddiu:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.srcImm = 1'b1;
				ctrl.useRx = 1'b1;
				dest = rx;
				imm = simm8;
			end
			cpuPkg::opLi:
			begin
				ctrl.aluOp = pipePkg::aluPassB;
				ctrl.regWrite = 1'b1;
				ctrl.srcImm = 1'b1;
				dest = rx;
				imm = zimm8;
			end
			cpuPkg::opLw:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.srcImm = 1'b1;
				ctrl.useRx = 1'b1;
				dest = ry;
				imm = simm5;
			end
			cpuPkg::opSw:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.srcImm = 1'b1;
				ctrl.useRx = 1'b1;
				ctrl.useRy = 1'b1;
				imm = simm5;
			end
			cpuPkg::opBeqz:
			begin
				ctrl.branchZero = 1'b1;
				ctrl.useRx = 1'b1;
				imm = simm8;
			end
			cpuPkg::opBnez:
			begin
				ctrl.branchNonZero = 1'b1;
				ctrl.useRx = 1'b1;
				imm = simm8;
			end
			cpuPkg::opB:
			begin
				ctrl.jumpImm = 1'b1;
				imm = simm11;
			end
			cpuPkg::opJr:
			begin
				ctrl.jumpReg = 1'b1;
				ctrl.useRx = 1'b1;
			end
			// NOP and unused codes
			default:
			begin
				ctrl = '0;
			end
		endcase
	end

endmodule

//--- rtl/pipeReg.sv
module pipeReg #(
	parameter type payloadT = logic
) (
	input  logic    CLK,
	input  logic    RST,
	input  logic    stall,
	input  logic    flush,
	input  payloadT d,
	output payloadT q
);

	// flush has priority so a squashed slot never survives a stall
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
			q <= '0;
		else if (flush)
			q <= '0;
		else if (!stall)
			q <= d;
	end

	// load-use stall and taken redirect come from different EX contents
	stallFlushExclusive: assert property (@(posedge CLK) disable iff (!RST) !(stall && flush))
		else $error("stall and flush high together");

endmodule

//--- rtl/pipePkg.sv
package pipePkg;

	typedef enum logic [2:0] {
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluAnd   = 3'd2,
		aluOr    = 3'd3,
		aluSlt   = 3'd4,
		aluPassB = 3'd5
	} aluOpT;

	// all-zero control is a NOP
	typedef struct packed {
		aluOpT aluOp;
		logic  srcImm;
		logic  regWrite;
		logic  memRead;
		logic  memWrite;
		logic  branchZero;
		logic  branchNonZero;
		logic  jumpImm;
		logic  jumpReg;
		logic  useRx;
		logic  useRy;
	} ctrlT;

	typedef enum logic [1:0] {
		fwdNone    = 2'd0,
		fwdFromMem = 2'd1,
		fwdFromWb  = 2'd2
	} fwdSelT;

	// ------------------------------
	// stage payloads, zero is a bubble
	// ------------------------------
	typedef struct packed {
		logic         valid;
		cpuPkg::wordT pc;
		cpuPkg::wordT instr;
	} ifIdT;

	typedef struct packed {
		logic           valid;
		ctrlT           ctrl;
		cpuPkg::wordT   pc;
		cpuPkg::wordT   rxVal;
		cpuPkg::wordT   ryVal;
		cpuPkg::wordT   imm;
		cpuPkg::regIdxT rx;
		cpuPkg::regIdxT ry;
		cpuPkg::regIdxT dest;
	} idExT;

	typedef struct packed {
		logic           valid;
		logic           regWrite;
		logic           memRead;
		logic           memWrite;
		cpuPkg::wordT   aluResult;
		cpuPkg::wordT   storeData;
		cpuPkg::regIdxT dest;
	} exMemT;

	typedef struct packed {
		logic           valid;
		logic           regWrite;
		cpuPkg::wordT   result;
		cpuPkg::regIdxT dest;
	} memWbT;

endpackage

//--- rtl/cpuPkg.sv
package cpuPkg;

	// ------------------------------
	// word and register sizes
	// ------------------------------
	localparam int dataWidth = 16;
	localparam int regCount = 8;
	localparam int regIdxWidth = $clog2(regCount);

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [regIdxWidth-1:0] regIdxT;

	// ------------------------------
	// instruction fields
	// ------------------------------
	localparam int opcodeMsb = 15;
	localparam int opcodeLsb = 11;
	localparam int opcodeWidth = opcodeMsb - opcodeLsb + 1;
	localparam int rxMsb = 10;
	localparam int rxLsb = 8;
	localparam int ryMsb = 7;
	localparam int ryLsb = 5;
	localparam int rzMsb = 4;
	localparam int rzLsb = 2;

	// immediates all start at bit 0
	localparam int imm8Width = 8;
	localparam int imm5Width = 5;
	localparam int imm11Width = 11;

	typedef enum logic [opcodeWidth-1:0] {
		opNop   = 5'd0,
		opAddu  = 5'd1,
		opSubu  = 5'd2,
		opAnd   = 5'd3,
		opOr    = 5'd4,
		opSlt   = 5'd5,
		opAddiu = 5'd6,
		opLi    = 5'd7,
		opLw    = 5'd8,
		opSw    = 5'd9,
		opBeqz  = 5'd10,
		opBnez  = 5'd11,
		opB     = 5'd12,
		opJr    = 5'd13
	} opcodeT;

	// opcode zero with every other field zero
	localparam wordT nopWord = '0;

endpackage
